//--- source/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

	// mantissa width, also the alignment distance past which an operand vanishes
	localparam int MANT_W = 40;

	// exponent width
	localparam int EXP_W = 8;

	// two's-complement fraction, bit 0 is the sign
	typedef logic signed [0:MANT_W-1] mant_t;

	// sum register with a guard sign bit in position -1
	typedef logic signed [-1:MANT_W-1] mant_ext_t;

	// two's-complement exponent
	typedef logic signed [EXP_W-1:0] exp_t;

	// exponent difference with the extra sign bit of the adder
	typedef logic signed [EXP_W:0] exp_diff_t;

	// alignment or normalization distance
	typedef logic [5:0] shift_t;

endpackage

`default_nettype wire

//--- source/fp_ctrl_pkg.sv
`default_nettype none

package fp_ctrl_pkg;

	// add or subtract select carried with each operand pair
	typedef enum logic {
		op_add,
		op_sub
	} op_t;

	// mantissa unit sequencing
	// s_fix handles the one-place overflow correction,
	// s_norm loops once per left shift
	typedef enum logic [2:0] {
		s_idle,
		s_add,
		s_fix,
		s_norm,
		s_done
	} sum_state_t;

endpackage

`default_nettype wire

//--- source/align_link_if.sv
`timescale 1ns/10ps
`default_nettype none

interface align_link_if;
	import fp_format_pkg::*;
	import fp_ctrl_pkg::*;

	// strobes
	logic push;
	logic pop;

	// aligned operation fields
	exp_t exp;
	mant_t mant_big;
	mant_t mant_small;
	logic big_is_b;
	op_t op;
	logic far;

	// occupancy levels
	logic full;
	logic empty;

	modport producer (
		output push, exp, mant_big, mant_small, big_is_b, op, far,
		input full
	);

	modport fifo_in (
		input push, exp, mant_big, mant_small, big_is_b, op, far,
		output full
	);

	modport fifo_out (
		input pop,
		output exp, mant_big, mant_small, big_is_b, op, far, empty
	);

	modport consumer (
		output pop,
		input exp, mant_big, mant_small, big_is_b, op, far, empty
	);

endinterface

`default_nettype wire

//--- source/exponent_align.sv
`timescale 1ns/10ps
`default_nettype none

module exponent_align (
	input wire logic f2strob,
	input wire logic reset,
	input wire logic op_strobe,
	input wire logic op_sub,
	input wire fp_format_pkg::exp_t a_exp,
	input wire fp_format_pkg::mant_t a_mant,
	input wire fp_format_pkg::exp_t b_exp,
	input wire fp_format_pkg::mant_t b_mant,
	align_link_if.producer link,
	output logic lost
);
	import fp_format_pkg::*;
	import fp_ctrl_pkg::*;

	exp_diff_t diff;
	exp_diff_t diff_mag;
	logic b_big;
	logic far_c;
	shift_t shift;
	mant_t small_mant;
	mant_t small_aligned;

	// a - b, sign-extended to nine bits so the sign never wraps
	assign diff = {a_exp[EXP_W-1], a_exp} - {b_exp[EXP_W-1], b_exp};

	// negative difference means b has the larger exponent
	assign b_big = diff[EXP_W];

	// magnitude tops out at 255, still positive in nine bits
	assign diff_mag = b_big ? -diff : diff;

	// smaller operand shifted completely out
	assign far_c = diff_mag >= MANT_W;

	// only meaningful when far_c is clear
	assign shift = diff_mag[5:0];

	assign small_mant = b_big ? a_mant : b_mant;

	// arithmetic shift keeps the sign, low bits are simply lost
	assign small_aligned = far_c ? mant_t'(0) : small_mant >>> shift;

	// FIFO drops a push while full, flag it the same cycle
	assign lost = link.push & link.full;

	always_ff @(posedge f2strob) begin
		if (reset) begin
			link.push <= 1'b0;
		end else begin
			link.push <= op_strobe;
		end
	end

	// entry fields, loaded with the strobe
	always_ff @(posedge f2strob) begin
		if (op_strobe) begin
			if (b_big) begin
				link.exp <= b_exp;
				link.mant_big <= b_mant;
			end else begin
				link.exp <= a_exp;
				link.mant_big <= a_mant;
			end
			link.mant_small <= small_aligned;
			link.big_is_b <= b_big;
			link.op <= op_t'(op_sub);
			link.far <= far_c;
		end
	end

endmodule

`default_nettype wire

//--- source/align_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module align_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input wire logic f2strob,
	input wire logic reset,
	align_link_if.fifo_in wr,
	align_link_if.fifo_out rd
);
	import fp_format_pkg::*;
	import fp_ctrl_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int OP_W = $bits(op_t);
	localparam int ENTRY_W = $bits(exp_t) + 2 * $bits(mant_t) + OP_W + 2;
	localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

	typedef logic [ENTRY_W-1:0] entry_t;

	entry_t mem [FIFO_DEPTH];
	entry_t head;
	logic [OP_W-1:0] head_op;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_write;
	logic do_read;

	assign wr.full = count == FULL_COUNT;
	assign rd.empty = count == '0;

	assign do_write = wr.push & ~wr.full;
	assign do_read = rd.pop & ~rd.empty;

	// head entry straight out of the array
	assign head = mem[rd_ptr];
	assign {rd.exp, rd.mant_big, rd.mant_small, rd.big_is_b, head_op, rd.far} = head;
	assign rd.op = op_t'(head_op);

	always_ff @(posedge f2strob) begin
		if (do_write) begin
			mem[wr_ptr] <= {wr.exp, wr.mant_big, wr.mant_small, wr.big_is_b, wr.op, wr.far};
		end
	end

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge f2strob) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/mantissa_sum.sv
`timescale 1ns/10ps
`default_nettype none

module mantissa_sum (
	input wire logic f2strob,
	input wire logic reset,
	align_link_if.consumer link,
	output logic res_strobe,
	output fp_format_pkg::exp_t res_exp,
	output fp_format_pkg::mant_t res_mant,
	output logic res_far,
	output logic z_f,
	output logic m_f,
	output logic v_f
);
	import fp_format_pkg::*;
	import fp_ctrl_pkg::*;

	// working exponent, two spare bits catch overflow both ways
	typedef logic signed [EXP_W+1:0] exp_track_t;

	sum_state_t state;
	mant_ext_t a_ext;
	mant_ext_t b_ext;
	mant_ext_t acc;
	exp_track_t exp_track;
	op_t op_r;
	logic far_r;
	logic acc_zero;
	logic acc_ovf;
	logic acc_denorm;

	// take the next entry only when idle
	assign link.pop = (state == s_idle) && !link.empty;

	assign acc_zero = acc == '0;

	// guard bit disagrees with the sign bit
	assign acc_ovf = acc[-1] != acc[0];

	// sign repeated in bit 1, one more left shift possible
	assign acc_denorm = !acc_zero && (acc[0] == acc[1]);

	always_ff @(posedge f2strob) begin
		if (reset) begin
			state <= s_idle;
			res_strobe <= 1'b0;
		end else begin
			res_strobe <= state == s_done;
			case (state)
				s_idle: begin
					if (link.pop) begin
						state <= s_add;
					end
				end
				s_add: state <= s_fix;
				s_fix: state <= s_norm;
				s_norm: begin
					if (!acc_denorm) begin
						state <= s_done;
					end
				end
				s_done: state <= s_idle;
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge f2strob) begin
		case (state)
			s_idle: begin
				if (link.pop) begin
					// put the operands back in a, b order for a - b
					if (link.big_is_b) begin
						a_ext <= {link.mant_small[0], link.mant_small};
						b_ext <= {link.mant_big[0], link.mant_big};
					end else begin
						a_ext <= {link.mant_big[0], link.mant_big};
						b_ext <= {link.mant_small[0], link.mant_small};
					end
					exp_track <= {{2{link.exp[EXP_W-1]}}, link.exp};
					op_r <= link.op;
					far_r <= link.far;
				end
			end
			s_add: begin
				if (op_r == op_sub) begin
					acc <= a_ext - b_ext;
				end else begin
					acc <= a_ext + b_ext;
				end
			end
			s_fix: begin
				// one right shift brings the guard back into range
				if (acc_ovf) begin
					acc <= acc >>> 1;
					exp_track <= exp_track + 1'b1;
				end
			end
			s_norm: begin
				if (acc_denorm) begin
					acc <= acc <<< 1;
					exp_track <= exp_track - 1'b1;
				end
			end
			s_done: begin
				res_mant <= acc[0:MANT_W-1];
				res_far <= far_r;
				m_f <= acc[0];
				z_f <= acc_zero;
				if (acc_zero) begin
					// zero result carries a clean exponent
					res_exp <= '0;
					v_f <= 1'b0;
				end else begin
					// wraps modulo 256
					res_exp <= exp_track[EXP_W-1:0];
					v_f <= exp_track[EXP_W+1:EXP_W-1] != {3{exp_track[EXP_W+1]}};
				end
			end
			default: begin
				acc <= acc;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/fpu_addsub.sv
`timescale 1ns/10ps
`default_nettype none

module fpu_addsub #(
	parameter int FIFO_DEPTH = 4
) (
	input wire logic f2strob,
	input wire logic reset,
	input wire logic op_strobe,
	input wire logic op_sub,
	input wire fp_format_pkg::exp_t a_exp,
	input wire fp_format_pkg::mant_t a_mant,
	input wire fp_format_pkg::exp_t b_exp,
	input wire fp_format_pkg::mant_t b_mant,
	output logic full,
	output logic lost,
	output logic res_strobe,
	output fp_format_pkg::exp_t res_exp,
	output fp_format_pkg::mant_t res_mant,
	output logic res_far,
	output logic z_f,
	output logic m_f,
	output logic v_f
);

	// exponent unit to FIFO
	align_link_if link_in ();

	// FIFO to mantissa unit
	align_link_if link_out ();

	exponent_align exponent_align_inst (
		.f2strob (f2strob),
		.reset (reset),
		.op_strobe (op_strobe),
		.op_sub (op_sub),
		.a_exp (a_exp),
		.a_mant (a_mant),
		.b_exp (b_exp),
		.b_mant (b_mant),
		.link (link_in.producer),
		.lost (lost)
	);

	align_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) align_fifo_inst (
		.f2strob (f2strob),
		.reset (reset),
		.wr (link_in.fifo_in),
		.rd (link_out.fifo_out)
	);

	mantissa_sum mantissa_sum_inst (
		.f2strob (f2strob),
		.reset (reset),
		.link (link_out.consumer),
		.res_strobe (res_strobe),
		.res_exp (res_exp),
		.res_mant (res_mant),
		.res_far (res_far),
		.z_f (z_f),
		.m_f (m_f),
		.v_f (v_f)
	);

	// source watches this before strobing
	assign full = link_in.full;

endmodule

`default_nettype wire

//--- testbench/fp_model.svh
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

// expected outcome of one operation, same field order as the compare
typedef struct packed {
	logic [7:0] exp;
	logic [39:0] mant;
	logic far;
	logic z;
	logic m;
	logic v;
} fp_result_t;

// fraction values 1.0 and 0.5 scaled to the 40-bit mantissa
localparam longint FRAC_ONE = 64'sh80_0000_0000;
localparam longint FRAC_HALF = 64'sh40_0000_0000;
localparam logic [31:0] LCG_SEED = 32'd3914;

logic [31:0] lcg_state = LCG_SEED;

function automatic logic [31:0] next_rand();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// random normalized fraction of either sign
function automatic logic [39:0] rand_mant();
	logic [31:0] hi;
	logic [31:0] lo;
	logic [39:0] m;
	hi = next_rand();
	lo = next_rand();
	m = {hi[31:24], lo};
	m[38] = ~m[39];
	return m;
endfunction

function automatic fp_result_t add_sub_model(input logic [7:0] a_exp, input logic [39:0] a_mant,
		input logic [7:0] b_exp, input logic [39:0] b_mant, input logic sub);
	fp_result_t r;
	int ea;
	int eb;
	int e;
	longint x;
	longint y;
	longint sum;
	ea = $signed(a_exp);
	eb = $signed(b_exp);
	x = $signed(a_mant);
	y = $signed(b_mant);
	r.far = (ea - eb >= 40) || (eb - ea >= 40);
	// smaller exponent side is shifted or vanishes
	if (eb > ea) begin
		e = eb;
		x = r.far ? 0 : x >>> (eb - ea);
	end else begin
		e = ea;
		y = r.far ? 0 : y >>> (ea - eb);
	end
	sum = sub ? x - y : x + y;
	if (sum >= FRAC_ONE || sum < -FRAC_ONE) begin
		sum = sum >>> 1;
		e++;
	end
	while (sum != 0 && sum >= -FRAC_HALF && sum < FRAC_HALF) begin
		sum = sum * 2;
		e--;
	end
	r.mant = sum[39:0];
	r.m = sum < 0;
	r.z = sum == 0;
	r.exp = r.z ? 8'd0 : e[7:0];
	r.v = !r.z && (e > 127 || e < -128);
	return r;
endfunction

`endif

//--- testbench/fpu_addsub_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fpu_addsub_tb;

	localparam int WAIT_LIMIT = 2000;

	logic f2strob = 1'b0;
	logic reset;
	logic op_strobe;
	logic op_sub;
	logic [7:0] a_exp;
	logic [39:0] a_mant;
	logic [7:0] b_exp;
	logic [39:0] b_mant;
	logic full;
	logic lost;
	logic res_strobe;
	logic [7:0] res_exp;
	logic [39:0] res_mant;
	logic res_far;
	logic z_f;
	logic m_f;
	logic v_f;

	`include "fp_model.svh"

	fp_result_t expected [$];
	int results = 0;

	fpu_addsub fpu_addsub_inst (.*);

	always #50 f2strob = ~f2strob;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] want);
		if (got !== want) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic next_cycle();
		@(posedge f2strob);
		#1;
	endtask

	// paced sends wait for room and let the write land before returning
	task automatic send_op(input logic [7:0] ae, input logic [39:0] am, input logic [7:0] be,
			input logic [39:0] bm, input logic sub, input logic paced, output logic dropped);
		fp_result_t want;
		int waited;
		waited = 0;
		while (paced && full) begin
			if (waited == WAIT_LIMIT) begin
				abort_run("FIFO stayed full for too long");
			end else begin
				waited++;
				next_cycle();
			end
		end
		want = add_sub_model(ae, am, be, bm, sub);
		a_exp = ae;
		a_mant = am;
		b_exp = be;
		b_mant = bm;
		op_sub = sub;
		op_strobe = 1'b1;
		next_cycle();
		op_strobe = 1'b0;
		// push of this operation is on the link now
		dropped = lost;
		if (!dropped) begin
			expected.push_back(want);
		end
		if (paced) begin
			check_value("lost for an operation sent with room", dropped, 0);
			next_cycle();
		end
	endtask

	initial begin
		fp_result_t want;
		forever begin
			@(negedge f2strob);
			if (res_strobe === 1'b1) begin
				if (expected.size() == 0) begin
					abort_run("result strobe without an accepted operation");
				end else begin
					want = expected.pop_front();
					results++;
					check_value($sformatf("result %0d {exp,mant,far,z,m,v}", results),
						{res_exp, res_mant, res_far, z_f, m_f, v_f}, want);
				end
			end
		end
	end

	initial begin
		logic dropped;
		logic saw_full;
		logic [31:0] r;
		logic [7:0] eb;
		logic [39:0] m;
		int waited;
		reset = 1'b1;
		op_strobe = 1'b0;
		op_sub = 1'b0;
		a_exp = '0;
		a_mant = '0;
		b_exp = '0;
		b_mant = '0;
		repeat (16) next_cycle();
		reset = 1'b0;
		check_value("res_strobe after reset", res_strobe, 0);
		check_value("lost after reset", lost, 0);
		check_value("full after reset", full, 0);
		// no result may appear while idle
		repeat (10) next_cycle();

		// equal exponents: overflow, normalization, exact cancellation
		send_op(8'd3, 40'h40_0000_0000, 8'd3, 40'h60_0000_0000, 1'b0, 1'b1, dropped);
		send_op(8'd3, 40'h40_0000_0000, 8'd3, 40'h60_0000_0000, 1'b1, 1'b1, dropped);
		m = rand_mant();
		send_op(8'd5, m, 8'd5, m, 1'b1, 1'b1, dropped);
		send_op(8'd5, m, 8'd5, -m, 1'b0, 1'b1, dropped);

		// every distance on both sides, far ones included
		for (int d = 1; d < 46; d++) begin
			send_op(8'd20, rand_mant(), 8'(20 - d), rand_mant(), d[0], 1'b1, dropped);
			send_op(8'(-d), rand_mant(), 8'd0, rand_mant(), d[1], 1'b1, dropped);
		end
		send_op(8'h80, rand_mant(), 8'd127, rand_mant(), 1'b1, 1'b1, dropped);

		// exponent leaving the range at the top and at the bottom
		send_op(8'd127, 40'h60_0000_0000, 8'd127, 40'h60_0000_0000, 1'b0, 1'b1, dropped);
		send_op(8'h80, 40'h40_0000_0001, 8'h80, 40'h40_0000_0000, 1'b1, 1'b1, dropped);

		// burst of slow near-cancelling subtractions
		saw_full = 1'b0;
		for (int i = 0; i < 8; i++) begin
			m = rand_mant();
			send_op(8'd0, m, 8'd0, m ^ 40'h3f, 1'b1, 1'b0, dropped);
			saw_full = saw_full | full;
		end
		check_value("full seen during the burst", saw_full, 1);
		// full with no pop pending keeps the FIFO full through the push
		waited = 0;
		while (!(full && !res_strobe)) begin
			if (waited == WAIT_LIMIT) begin
				abort_run("FIFO never filled after the burst");
			end else begin
				waited++;
				next_cycle();
			end
		end
		send_op(8'd1, rand_mant(), 8'd1, rand_mant(), 1'b0, 1'b0, dropped);
		check_value("lost for a strobe while full", dropped, 1);

		for (int i = 0; i < 150; i++) begin
			r = next_rand();
			eb = r[14] ? r[31:24] : r[31:24] + r[23:18] - 8'd20;
			send_op(r[31:24], rand_mant(), eb, rand_mant(), r[13], 1'b1, dropped);
		end

		waited = 0;
		while (expected.size() != 0) begin
			if (waited == WAIT_LIMIT) begin
				abort_run("results stopped before every accepted operation finished");
			end else begin
				waited++;
				next_cycle();
			end
		end
		// any late extra result is caught by the compare process
		repeat (20) next_cycle();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+testbench
source/fp_format_pkg.sv
source/fp_ctrl_pkg.sv
source/align_link_if.sv
source/exponent_align.sv
source/align_fifo.sv
source/mantissa_sum.sv
source/fpu_addsub.sv
testbench/fpu_addsub_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator and run the testbench

verilator --binary --timing -Wno-fatal -f vlog.f --top-module fpu_addsub_tb -o sim_fpu_addsub
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/sim_fpu_addsub 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
	exit 0
fi
echo "pass line missing from simulation output"
exit 1
